// ==== common/meter_params.svh ====
`ifndef METER_PARAMS_SVH
`define METER_PARAMS_SVH

// Bus geometry
`define AXI_DATA_WIDTH 32
`define AXI_ADDR_WIDTH 16
`define AXI_ADDR_LSB   2     // Byte offset bits inside one 32-bit word
`define AXI_RESP_OKAY  2'b00

// Register map sizes
`define CFG_WORDS     2
`define STS_WORDS     4
`define CFG_IDX_WIDTH $clog2(`CFG_WORDS)
`define STS_IDX_WIDTH $clog2(`STS_WORDS)

// Meter datapath
`define CNT_WIDTH 32

`endif

// ==== common/axi_lite_pkg.sv ====
`include "meter_params.svh"

package axi_lite_pkg;

  // Master to slave, write address and write data joined with the response ready
  typedef struct packed {
    logic [`AXI_ADDR_WIDTH-1:0] awaddr;
    logic                       awvalid;
    logic [`AXI_DATA_WIDTH-1:0] wdata;
    logic                       wvalid;
    logic                       bready;
  } axi_wr_req_t;

  typedef struct packed {
    logic       awready;
    logic       wready;
    logic [1:0] bresp;
    logic       bvalid;
  } axi_wr_rsp_t;

  typedef struct packed {
    logic [`AXI_ADDR_WIDTH-1:0] araddr;
    logic                       arvalid;
    logic                       rready;
  } axi_rd_req_t;

  typedef struct packed {
    logic                       arready;
    logic [`AXI_DATA_WIDTH-1:0] rdata;
    logic [1:0]                 rresp;
    logic                       rvalid;
  } axi_rd_rsp_t;

endpackage

// ==== common/meter_pkg.sv ====
`include "meter_params.svh"

package meter_pkg;

  // Configuration word map
  localparam int unsigned CFG_CTRL    = 0;
  localparam int unsigned CFG_GATE    = 1;
  localparam int unsigned CTRL_ENABLE = 0; // Bit positions in the control word
  localparam int unsigned CTRL_CLEAR  = 1;

  // Status word map
  localparam int unsigned STS_LAST    = 0;
  localparam int unsigned STS_RUN     = 1;
  localparam int unsigned STS_WINDOWS = 2;
  localparam int unsigned STS_FLAGS   = 3;

  typedef struct packed {
    logic                  enable;
    logic [`CNT_WIDTH-1:0] gate_len;
  } meter_cfg_t;

  typedef struct packed {
    logic [`AXI_DATA_WIDTH-4:0] reserved;
    logic                       overflow; // Bit 2
    logic                       busy;     // Bit 1
    logic                       enable;   // Bit 0
  } meter_flags_t;

  // Word 0 sits in the low bits so that word i is bits [32*i +: 32]
  typedef struct packed {
    meter_flags_t               flags;
    logic [`AXI_DATA_WIDTH-1:0] windows;
    logic [`AXI_DATA_WIDTH-1:0] run_count;
    logic [`AXI_DATA_WIDTH-1:0] last_count;
  } meter_sts_t;

endpackage

// ==== hw/axi_cfg_register.sv ====
`timescale 1ns/1ns
`include "meter_params.svh"

module axi_cfg_register (
  input  logic                      aclk,
  input  logic                      aresetn,
  input  axi_lite_pkg::axi_wr_req_t wr_req,
  output axi_lite_pkg::axi_wr_rsp_t wr_rsp,
  output meter_pkg::meter_cfg_t     cfg,
  output logic                      clear
);

  import meter_pkg::*;

  logic [`CFG_IDX_WIDTH-1:0] wr_idx;
  logic                      wr_accept;
  logic                      bvalid;
  logic                      enable_q;
  logic [`CNT_WIDTH-1:0]     gate_len_q;
  logic                      clear_q;

  // Word index wraps because only the low index bits are kept
  assign wr_idx = wr_req.awaddr[`AXI_ADDR_LSB +: `CFG_IDX_WIDTH];

  // Address and data are taken together, never while a response is pending
  assign wr_accept = wr_req.awvalid & wr_req.wvalid & ~bvalid;

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      enable_q   <= 1'b0;
      gate_len_q <= '0;
      clear_q    <= 1'b0;
      bvalid     <= 1'b0;
    end
    else
    begin
      clear_q <= 1'b0; // Pulse lasts one cycle only
      if (wr_accept)
      begin
        bvalid <= 1'b1;
        if (wr_idx == CFG_CTRL)
        begin
          enable_q <= wr_req.wdata[CTRL_ENABLE];
          clear_q  <= wr_req.wdata[CTRL_CLEAR]; // Request bit is not kept
        end
        else if (wr_idx == CFG_GATE)
        begin
          gate_len_q <= wr_req.wdata;
        end
      end
      else if (wr_req.bready)
      begin
        bvalid <= 1'b0;
      end
    end
  end

  always_comb
  begin
    wr_rsp.awready = wr_accept;
    wr_rsp.wready  = wr_accept;
    wr_rsp.bresp   = `AXI_RESP_OKAY;
    wr_rsp.bvalid  = bvalid;
  end

  always_comb
  begin
    cfg.enable   = enable_q;
    cfg.gate_len = gate_len_q;
  end

  assign clear = clear_q;

endmodule

// ==== hw/axi_sts_register.sv ====
`timescale 1ns/1ns
`include "meter_params.svh"

module axi_sts_register (
  input  logic                      aclk,
  input  logic                      aresetn,
  input  meter_pkg::meter_sts_t     sts,
  input  axi_lite_pkg::axi_rd_req_t rd_req,
  output axi_lite_pkg::axi_rd_rsp_t rd_rsp
);

  import meter_pkg::*;

  logic [`AXI_DATA_WIDTH-1:0] sts_words [`STS_WORDS];
  logic [`STS_IDX_WIDTH-1:0]  rd_idx;
  logic                       rvalid;
  logic [`AXI_DATA_WIDTH-1:0] rdata;

  // Split the status vector into addressable words
  always_comb
  begin
    sts_words[STS_LAST]    = sts.last_count;
    sts_words[STS_RUN]     = sts.run_count;
    sts_words[STS_WINDOWS] = sts.windows;
    sts_words[STS_FLAGS]   = sts.flags;
  end

  assign rd_idx = rd_req.araddr[`AXI_ADDR_LSB +: `STS_IDX_WIDTH]; // Wraps modulo word count

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      rvalid <= 1'b0;
    end
    else if (rd_req.arvalid)
    begin
      rvalid <= 1'b1;
    end
    else if (rd_req.rready)
    begin
      rvalid <= 1'b0;
    end
  end

  // Captured once per request and held until the master takes it
  always_ff @(posedge aclk)
  begin
    if (rd_req.arvalid)
    begin
      rdata <= sts_words[rd_idx];
    end
  end

  always_comb
  begin
    rd_rsp.arready = 1'b1;
    rd_rsp.rdata   = rdata;
    rd_rsp.rresp   = `AXI_RESP_OKAY;
    rd_rsp.rvalid  = rvalid;
  end

endmodule

// ==== edge_meter/edge_meter.sv ====
`timescale 1ns/1ns
`include "meter_params.svh"

module edge_meter (
  input  logic                  aclk,
  input  logic                  aresetn,
  input  meter_pkg::meter_cfg_t cfg,
  input  logic                  clear,
  input  logic                  pulse_in,
  output meter_pkg::meter_sts_t sts
);

  import meter_pkg::*;

  logic [2:0]            sync_q;     // Two synchronizer stages plus one history stage
  logic                  rise;
  logic                  active;
  logic                  active_d;
  logic                  start;
  logic                  gate_done;
  logic [`CNT_WIDTH-1:0] gate_cnt;
  logic [`CNT_WIDTH-1:0] run_count;
  logic [`CNT_WIDTH-1:0] last_count;
  logic [`CNT_WIDTH-1:0] windows;
  logic [`CNT_WIDTH-1:0] run_base;
  logic [`CNT_WIDTH-1:0] run_next;
  logic                  run_max;
  logic                  overflow;
  meter_flags_t          flags;

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      sync_q   <= '0;
      active_d <= 1'b0;
    end
    else
    begin
      sync_q   <= {sync_q[1:0], pulse_in};
      active_d <= active;
    end
  end

  assign rise   = sync_q[1] & ~sync_q[2];
  assign active = cfg.enable & (cfg.gate_len != '0); // Zero length counts as disabled
  assign start  = active & ~active_d;

  // A new gate also drops whatever was left of an earlier run
  assign gate_done = active & (gate_cnt >= cfg.gate_len - 1'b1);
  assign run_base  = start ? '0 : run_count;
  assign run_max   = &run_base;
  assign run_next  = run_base + {{(`CNT_WIDTH-1){1'b0}}, rise & ~run_max}; // Saturates

  always_ff @(posedge aclk)
  begin
    if (!aresetn || clear)
    begin
      gate_cnt   <= '0;
      run_count  <= '0;
      last_count <= '0;
      windows    <= '0;
      overflow   <= 1'b0;
    end
    else if (!active)
    begin
      gate_cnt <= '0; // Next enable starts from the top of a gate
    end
    else
    begin
      if (gate_done)
      begin
        gate_cnt   <= '0;
        last_count <= run_next; // Edge in the final cycle still belongs to this window
        run_count  <= '0;
        windows    <= windows + 1'b1;
      end
      else
      begin
        gate_cnt  <= gate_cnt + 1'b1;
        run_count <= run_next;
      end
      if (rise && run_max)
      begin
        overflow <= 1'b1;
      end
    end
  end

  always_comb
  begin
    flags          = '0;
    flags.enable   = cfg.enable;
    flags.busy     = active;
    flags.overflow = overflow;
  end

  always_comb
  begin
    sts.last_count = last_count;
    sts.run_count  = run_count;
    sts.windows    = windows;
    sts.flags      = flags;
  end

endmodule

// ==== hw/meter_top.sv ====
`timescale 1ns/1ns

module meter_top (
  input  logic                      aclk,
  input  logic                      aresetn,
  input  logic                      pulse_in,  // Asynchronous to aclk
  input  axi_lite_pkg::axi_wr_req_t wr_req,
  output axi_lite_pkg::axi_wr_rsp_t wr_rsp,
  input  axi_lite_pkg::axi_rd_req_t rd_req,
  output axi_lite_pkg::axi_rd_rsp_t rd_rsp
);

  import meter_pkg::*;

  meter_cfg_t cfg;
  logic       clear;
  meter_sts_t sts;

  // Writes only ever reach the configuration side
  axi_cfg_register u_cfg (
    .aclk    (aclk),
    .aresetn (aresetn),
    .wr_req  (wr_req),
    .wr_rsp  (wr_rsp),
    .cfg     (cfg),
    .clear   (clear)
  );

  edge_meter u_meter (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .cfg      (cfg),
    .clear    (clear),
    .pulse_in (pulse_in),
    .sts      (sts)
  );

  // Reads only ever reach the status side
  axi_sts_register u_sts (
    .aclk    (aclk),
    .aresetn (aresetn),
    .sts     (sts),
    .rd_req  (rd_req),
    .rd_rsp  (rd_rsp)
  );

endmodule

// ==== dv/meter_tb.sv ====
`timescale 1ns/1ns
`include "meter_params.svh"

module meter_tb;

  import axi_lite_pkg::*;
  import meter_pkg::*;

  localparam int RESET_CYCLES = 10;
  localparam int GATE_LEN     = 200;
  localparam int PULSE_HIGH   = 4;
  localparam int PULSE_LOW    = 2;  // 20 pulses fit in 120 cycles
  // Tests 3 and 4 span about three gates and the bus sequences add a few hundred cycles
  localparam int TEST_CYCLES  = RESET_CYCLES + 3 * GATE_LEN + 500;
  localparam int CYCLE_LIMIT  = 3 * TEST_CYCLES;

  logic        aclk;
  logic        aresetn;
  logic        pulse_in;
  axi_wr_req_t wr_req;
  axi_wr_rsp_t wr_rsp;
  axi_rd_req_t rd_req;
  axi_rd_rsp_t rd_rsp;
  int          errors;
  int          checks;
  int          cycle_count = 0;
  logic [31:0] rng_state;

  meter_top dut (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .pulse_in (pulse_in),
    .wr_req   (wr_req),
    .wr_rsp   (wr_rsp),
    .rd_req   (rd_req),
    .rd_rsp   (rd_rsp)
  );

  initial
  begin
    aclk = 1'b0;
    forever #50 aclk = ~aclk;
  end

  always @(posedge aclk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT)
    begin
      $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Simulation failed");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic logic [`AXI_ADDR_WIDTH-1:0] word_addr(input int idx);
    return idx << `AXI_ADDR_LSB;
  endfunction

  // Flags word: bit 0 enable, bit 1 busy, bit 2 overflow
  function automatic logic [`AXI_DATA_WIDTH-1:0] flags_word(input logic en, busy, ovf);
    return {{(`AXI_DATA_WIDTH-3){1'b0}}, ovf, busy, en};
  endfunction

  task automatic check_word(input string name, input logic [`AXI_DATA_WIDTH-1:0] expected,
                            input logic [`AXI_DATA_WIDTH-1:0] actual);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("[ERROR] %0t ns %s expected 0x%08h actual 0x%08h", $time, name, expected, actual);
    end
  endtask

  task automatic check_resp(input string name, input logic [1:0] expected,
                            input logic [1:0] actual);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("[ERROR] %0t ns %s expected 2'b%02b actual 2'b%02b", $time, name, expected, actual);
    end
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("Failure at %0t ns: %s", $time, what);
  endtask

  task automatic axi_write(input int idx, input logic [`AXI_DATA_WIDTH-1:0] data);
    @(posedge aclk);
    wr_req.awaddr  <= word_addr(idx);
    wr_req.wdata   <= data;
    wr_req.awvalid <= 1'b1;
    wr_req.wvalid  <= 1'b1;
    wr_req.bready  <= 1'b1;
    do @(negedge aclk); while (!wr_rsp.awready);
    if (!wr_rsp.wready)
      report_failure("wready did not rise together with awready");
    @(posedge aclk);
    wr_req.awvalid <= 1'b0;
    wr_req.wvalid  <= 1'b0;
    do @(negedge aclk); while (!wr_rsp.bvalid);
    check_resp("bresp", `AXI_RESP_OKAY, wr_rsp.bresp);
    @(posedge aclk);
    wr_req.bready <= 1'b0;
  endtask

  task automatic axi_read(input int idx, input logic ready, output logic [31:0] data);
    @(posedge aclk);
    rd_req.araddr  <= word_addr(idx);
    rd_req.arvalid <= 1'b1;
    rd_req.rready  <= ready;
    do @(negedge aclk); while (!rd_rsp.arready);
    @(posedge aclk);
    rd_req.arvalid <= 1'b0;
    do @(negedge aclk); while (!rd_rsp.rvalid);
    data = rd_rsp.rdata;
    check_resp("rresp", `AXI_RESP_OKAY, rd_rsp.rresp);
    if (ready)
    begin
      @(posedge aclk);
      rd_req.rready <= 1'b0;
    end
  endtask

  task automatic expect_word(input int idx, input logic [31:0] expected, input string name);
    logic [31:0] data;
    axi_read(idx, 1'b1, data);
    check_word(name, expected, data);
  endtask

  task automatic send_pulse();
    @(posedge aclk);
    pulse_in <= 1'b1;
    repeat (PULSE_HIGH) @(posedge aclk);
    pulse_in <= 1'b0;
    repeat (PULSE_LOW - 1) @(posedge aclk);
  endtask

  task automatic wait_windows(input int target, output logic [31:0] count);
    count = 0;
    while (count < target)
    begin
      axi_read(STS_WINDOWS, 1'b1, count);
    end
  endtask

  task automatic test_reset_state();
    expect_word(STS_LAST, 0, "last_count");
    expect_word(STS_RUN, 0, "run_count");
    expect_word(STS_WINDOWS, 0, "windows");
    expect_word(STS_FLAGS, 0, "flags");
  endtask

  task automatic test_config_steers();
    axi_write(CFG_GATE, GATE_LEN);
    axi_write(CFG_CTRL, 32'h1);
    expect_word(STS_FLAGS, flags_word(1'b1, 1'b1, 1'b0), "flags");
    axi_write(CFG_CTRL, 32'h0);
    expect_word(STS_FLAGS, flags_word(1'b0, 1'b0, 1'b0), "flags");
  endtask

  task automatic test_window_count();
    int          n;
    logic [31:0] win;
    n = (xorshift32() % 20) + 1;
    axi_write(CFG_GATE, GATE_LEN);
    axi_write(CFG_CTRL, 32'h3);  // Enable and start from zeroed counters
    repeat (n) send_pulse();
    wait_windows(1, win);
    check_word("windows", 1, win);
    expect_word(STS_LAST, n, "last_count");
    wait_windows(2, win);  // Second gate sees no pulses
    check_word("windows", 2, win);
    expect_word(STS_LAST, 0, "last_count");
  endtask

  task automatic test_clear();
    logic [31:0] win;
    repeat (3) send_pulse();
    wait_windows(3, win);  // Third gate closes with three edges in it
    check_word("windows", 3, win);
    expect_word(STS_LAST, 3, "last_count");
    send_pulse();
    repeat (4) @(posedge aclk);
    expect_word(STS_RUN, 1, "run_count");
    axi_write(CFG_CTRL, 32'h3);
    expect_word(STS_WINDOWS, 0, "windows");
    expect_word(STS_LAST, 0, "last_count");
    expect_word(STS_RUN, 0, "run_count");
    expect_word(STS_FLAGS, flags_word(1'b1, 1'b1, 1'b0), "flags");
  endtask

  task automatic test_back_pressure();
    logic [31:0] held;
    @(posedge aclk);
    wr_req.awaddr  <= word_addr(CFG_GATE);
    wr_req.wdata   <= GATE_LEN;
    wr_req.awvalid <= 1'b1;
    wr_req.wvalid  <= 1'b1;
    wr_req.bready  <= 1'b0;
    do @(negedge aclk); while (!wr_rsp.awready);
    if (!wr_rsp.wready)
      report_failure("wready did not rise together with awready");
    @(posedge aclk);  // Request stays up and acts as a second write
    repeat (5)
    begin
      @(negedge aclk);
      if (!wr_rsp.bvalid)
        report_failure("bvalid fell while bready was held low");
      if (wr_rsp.awready || wr_rsp.wready)
        report_failure("a second write was accepted while a response was pending");
    end
    @(posedge aclk);
    wr_req.awvalid <= 1'b0;
    wr_req.wvalid  <= 1'b0;
    wr_req.bready  <= 1'b1;
    do @(negedge aclk); while (wr_rsp.bvalid);
    @(posedge aclk);
    wr_req.bready <= 1'b0;
    axi_read(STS_RUN, 1'b0, held);
    check_word("run_count", 0, held);
    @(posedge aclk);
    pulse_in <= 1'b1;  // Edge reaches run_count while the read data is held
    repeat (5)
    begin
      @(negedge aclk);
      if (!rd_rsp.rvalid)
        report_failure("rvalid fell while rready was held low");
      check_word("rdata", held, rd_rsp.rdata);
    end
    @(posedge aclk);
    pulse_in      <= 1'b0;
    rd_req.rready <= 1'b1;
    do @(negedge aclk); while (rd_rsp.rvalid);
    @(posedge aclk);
    rd_req.rready <= 1'b0;
    expect_word(STS_RUN, 1, "run_count");
  endtask

  task automatic test_address_wrap();
    logic [31:0] word1;
    logic [31:0] word5;
    axi_write(CFG_CTRL, 32'h3);  // Fresh gate with empty counters
    repeat (3) send_pulse();
    repeat (4) @(posedge aclk);  // Let the last edge pass the synchronizer
    axi_write(CFG_CTRL, 32'h0);  // Frozen counters keep the value stable
    axi_read(STS_RUN, 1'b1, word1);
    check_word("run_count", 3, word1);
    axi_read(STS_RUN + `STS_WORDS, 1'b1, word5);
    check_word("rdata at word 5", 3, word5);
  endtask

  initial
  begin
    errors    = 0;
    checks    = 0;
    rng_state = 32'd36429;
    aresetn   = 1'b0;
    pulse_in  = 1'b0;
    wr_req    = '0;
    rd_req    = '0;
    repeat (RESET_CYCLES) @(posedge aclk);
    aresetn <= 1'b1;
    test_reset_state();
    test_config_steers();
    test_window_count();
    test_clear();
    test_back_pressure();
    test_address_wrap();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+common
common/axi_lite_pkg.sv
common/meter_pkg.sv
hw/axi_cfg_register.sv
hw/axi_sts_register.sv
edge_meter/edge_meter.sv
hw/meter_top.sv
dv/meter_tb.sv
